/* blit_addr_ctrl.f */
+incdir+source
source/blit_pkg.sv
source/blit_cmd_regs.sv
source/addr_adder_sel.sv
source/phrase_end_clip.sv
source/pixel_extent.sv
source/blit_addr_ctrl.sv
tests/blit_addr_ctrl_properties.sv
tests/blit_addr_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the blitter address control testbench

VERILATOR ?= verilator
TOP ?= blit_addr_ctrl_tb
FILELIST ?= blit_addr_ctrl.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= Regression passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard source/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/blit_addr_ctrl_tb.sv */
// Directed testbench for the blitter address control block
`include "blit_macros.svh"
`default_nettype none

module blit_addr_ctrl_tb;
	import blit_pkg::*;

	// DUT inputs
	logic sys_clk;
	logic reset;
	logic cmdld;
	logic a1_flags_ld;
	logic a2_flags_ld;
	logic [`BLIT_GPU_W-1:0] gpu_din;
	logic a1updatei;
	logic a1fupdatei;
	logic a2updatei;
	logic srca_addi;
	logic dsta_addi;
	logic [1:0] atick;
	logic [`BLIT_PTR_X_W-1:0] a1_x;
	logic [`BLIT_PTR_X_W-1:0] a2_x;
	logic [`BLIT_WIN_X_W-1:0] a1_win_x;
	logic [2:0] pixa;
	logic [2:0] icount;
	logic inner0;
	logic step_inner;
	logic dest_cycle_1;

	// DUT outputs
	logic dsta2;
	logic [2:0] addasel;
	logic [1:0] addbsel;
	logic addareg;
	logic addqsel;
	logic [2:0] adda_xconst;
	logic adda_yconst;
	logic [2:0] modx;
	logic suba_x;
	logic suba_y;
	logic a1ptrldi;
	logic a1fracldi;
	logic a2ptrldi;
	pixsize_t pixsize;
	logic [`BLIT_PTR_X_W-1:0] dstxp;
	logic phrase_mode;
	logic phrase_cycle;
	phrase_ofs_t dstart;
	phrase_ofs_t dend;
	logic [3:0] pwidth;

	// Result counters
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	blit_addr_ctrl DUT (.*);

	// 8-unit clock
	always #4 sys_clk = ~sys_clk;

	// Advance one edge and settle just past it
	task automatic tick();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic mismatch(string name, logic [31:0] got, logic [31:0] expected);
		$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
		test_errors++;
	endtask

	// One result line per test
	task automatic finish_test(string name);
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", name, test_errors);
		end else begin
			$display("%s: ok", name);
		end
		test_errors = 0;
	endtask

	// Flags word with the pixel size, X add mode and X sign fields
	function automatic logic [`BLIT_GPU_W-1:0] flags_word(logic [2:0] ps, logic [1:0] addx,
		logic xsign);
		logic [`BLIT_GPU_W-1:0] w;
		w = '0;
		w[`BLIT_FLG_PIXSIZE_LSB +: 3] = ps;
		w[`BLIT_FLG_ADDX_LSB +: 2] = addx;
		w[`BLIT_FLG_XSIGN_BIT] = xsign;
		return w;
	endfunction

	// Write one pointer's flags word
	task automatic load_flags(logic to_a2, logic [`BLIT_GPU_W-1:0] word);
		gpu_din = word;
		a1_flags_ld = ~to_a2;
		a2_flags_ld = to_a2;
		tick();
		a1_flags_ld = 1'b0;
		a2_flags_ld = 1'b0;
	endtask

	// Command write, destination select follows on the next edge
	task automatic load_command(logic dst_a2);
		gpu_din = '0;
		gpu_din[`BLIT_CMD_DSTA2_BIT] = dst_a2;
		cmdld = 1'b1;
		tick();
		cmdld = 1'b0;
		if (dsta2 !== dst_a2) mismatch("dsta2", dsta2, dst_a2);
	endtask

	// Drive the cycle phase and check the active pointer's phrase mode
	task automatic check_phrase_cycle(logic dest_cycle, logic expected);
		dest_cycle_1 = dest_cycle;
		tick();
		if (phrase_cycle !== expected) mismatch("phrase_cycle", phrase_cycle, expected);
	endtask

	task automatic reset_state();
		if (a1ptrldi !== 1'b0) mismatch("a1ptrldi", a1ptrldi, 0);
		if (a1fracldi !== 1'b0) mismatch("a1fracldi", a1fracldi, 0);
		if (a2ptrldi !== 1'b0) mismatch("a2ptrldi", a2ptrldi, 0);
		if (addqsel !== 1'b0) mismatch("addqsel", addqsel, 0);
		if (addareg !== 1'b0) mismatch("addareg", addareg, 0);
		if (dstart !== 6'd0) mismatch("dstart", dstart, 0);
		if (dend !== 6'd0) mismatch("dend", dend, 0);
		// Empty pipeline reads as a full phrase
		if (pwidth !== 4'd8) mismatch("pwidth", pwidth, 8);
		finish_test("reset_state");
	endtask

	task automatic flags_select();
		logic [2:0] ps1;
		logic [2:0] ps2;
		logic [1:0] mode;
		for (int i = 0; i < 4; i++) begin
			ps1 = 3'($urandom_range(5));
			ps2 = 3'($urandom_range(5));
			mode = 2'(i);
			a1_x = 16'h0a00 + 16'(i);
			a2_x = 16'h0b00 + 16'(i);
			load_flags(1'b0, flags_word(ps1, ADDX_PIXEL, 1'b0));
			load_flags(1'b1, flags_word(ps2, mode, 1'b0));
			load_command(1'b1);
			if (pixsize !== ps2) mismatch("pixsize", pixsize, ps2);
			if (phrase_mode !== (mode == 2'd0)) mismatch("phrase_mode", phrase_mode, mode == 2'd0);
			if (dstxp !== a2_x) mismatch("dstxp", dstxp, a2_x);
			// Destination pointer in its own cycle, source pointer otherwise
			check_phrase_cycle(1'b1, mode == 2'd0);
			check_phrase_cycle(1'b0, 1'b0);
			// Back to A1 as destination
			load_command(1'b0);
			if (pixsize !== ps1) mismatch("pixsize", pixsize, ps1);
			if (phrase_mode !== 1'b0) mismatch("phrase_mode", phrase_mode, 0);
			if (dstxp !== a1_x) mismatch("dstxp", dstxp, a1_x);
			check_phrase_cycle(1'b1, 1'b0);
			check_phrase_cycle(1'b0, mode == 2'd0);
		end
		finish_test("flags_select");
	endtask

	task automatic adder_steer();
		logic [`BLIT_GPU_W-1:0] word;
		load_command(1'b0);
		load_flags(1'b0, flags_word(3'd3, ADDX_PIXEL, 1'b0));
		// Fraction update alone goes through the fraction register
		a1fupdatei = 1'b1;
		tick();
		a1fupdatei = 1'b0;
		if (addasel[0] !== 1'b1) mismatch("addasel[0]", addasel[0], 1);
		if (addbsel[1] !== 1'b1) mismatch("addbsel[1]", addbsel[1], 1);
		if (addareg !== 1'b1) mismatch("addareg", addareg, 1);
		if (a1fracldi !== 1'b1) mismatch("a1fracldi", a1fracldi, 1);
		// Destination add in fraction mode, first tick phase
		load_flags(1'b0, flags_word(3'd3, ADDX_FRAC, 1'b0));
		dsta_addi = 1'b1;
		atick = 2'b01;
		tick();
		dsta_addi = 1'b0;
		atick = 2'b00;
		if (addasel[0] !== 1'b1) mismatch("addasel[0]", addasel[0], 1);
		if (addbsel[1] !== 1'b1) mismatch("addbsel[1]", addbsel[1], 1);
		if (addareg !== 1'b1) mismatch("addareg", addareg, 1);
		if (addqsel !== 1'b1) mismatch("addqsel", addqsel, 1);
		// No phrase modulo outside phrase adds
		if (modx !== 3'd0) mismatch("modx", modx, 0);
		// Pixel add with a negative X step and a Y add
		word = flags_word(3'd3, ADDX_PIXEL, 1'b1);
		word[`BLIT_FLG_ADDY_BIT] = 1'b1;
		load_flags(1'b0, word);
		dsta_addi = 1'b1;
		tick();
		dsta_addi = 1'b0;
		atick = 2'b10;
		#1;
		if (suba_x !== 1'b1) mismatch("suba_x", suba_x, 1);
		// Y add without a Y sign still adds
		if (suba_y !== 1'b0) mismatch("suba_y", suba_y, 0);
		if (adda_yconst !== 1'b1) mismatch("adda_yconst", adda_yconst, 1);
		// One pixel per step
		if (adda_xconst !== 3'd0) mismatch("adda_xconst", adda_xconst, 0);
		if (modx !== 3'd0) mismatch("modx", modx, 0);
		// Pointer load lands on the second tick phase
		if (a1ptrldi !== 1'b1) mismatch("a1ptrldi", a1ptrldi, 1);
		if (a2ptrldi !== 1'b0) mismatch("a2ptrldi", a2ptrldi, 0);
		tick();
		atick = 2'b00;
		// Source add while A1 is the destination lands on A2
		load_flags(1'b1, flags_word(PIX32, ADDX_PHRASE, 1'b0));
		srca_addi = 1'b1;
		atick = 2'b10;
		tick();
		srca_addi = 1'b0;
		if (a2ptrldi !== 1'b1) mismatch("a2ptrldi", a2ptrldi, 1);
		if (a1ptrldi !== 1'b0) mismatch("a1ptrldi", a1ptrldi, 0);
		// Two 32 bpp pixels per phrase
		if (adda_xconst !== 3'd1) mismatch("adda_xconst", adda_xconst, 1);
		if (modx !== 3'd1) mismatch("modx", modx, 1);
		tick();
		atick = 2'b00;
		finish_test("adder_steer");
	endtask

	task automatic pixel_extent_mode();
		logic [2:0] ps;
		logic [2:0] pa;
		logic [5:0] exp_end;
		load_command(1'b0);
		for (int i = 0; i < 6; i++) begin
			ps = 3'($urandom_range(5));
			pa = 3'($urandom_range(7));
			load_flags(1'b0, flags_word(ps, ADDX_PIXEL, 1'b0));
			// One pixel wide, in bits
			exp_end = 6'(pa) + (6'd1 << ps);
			pixa = pa;
			atick = 2'b10;
			step_inner = 1'b1;
			tick();
			atick = 2'b00;
			step_inner = 1'b0;
			tick();
			if (phrase_mode !== 1'b0) mismatch("phrase_mode", phrase_mode, 0);
			if (dstart !== 6'(pa)) mismatch("dstart", dstart, pa);
			if (dend !== exp_end) mismatch("dend", dend, exp_end);
		end
		finish_test("pixel_extent_mode");
	endtask

	// One 16 bpp phrase step, offsets in bytes
	task automatic clip_case(logic [15:0] x, logic [14:0] win, logic [2:0] icnt, logic in0);
		logic [2:0] start_b;
		logic [2:0] win_end;
		logic [2:0] inner_end;
		logic [2:0] end_b;
		logic [3:0] width;
		// Four pixels per phrase, two bytes each
		start_b = {x[1:0], 1'b0};
		win_end = (x[14:2] == win[14:2]) ? {win[1:0], 1'b0} : 3'd0;
		inner_end = in0 ? {icnt[1:0], 1'b0} : 3'd0;
		// Zero is the whole phrase
		if (win_end == 3'd0) begin
			end_b = inner_end;
		end else if (inner_end == 3'd0) begin
			end_b = win_end;
		end else begin
			end_b = (inner_end < win_end) ? inner_end : win_end;
		end
		width = (end_b == 3'd0 ? 4'd8 : {1'b0, end_b}) - {1'b0, start_b};
		a1_x = x;
		a1_win_x = win;
		icount = icnt;
		inner0 = in0;
		atick = 2'b10;
		step_inner = 1'b1;
		tick();
		atick = 2'b00;
		step_inner = 1'b0;
		// Width leads the offsets by a cycle
		if (pwidth !== width) mismatch("pwidth", pwidth, width);
		tick();
		if (dstart[5:3] !== start_b) mismatch("dstart[5:3]", dstart[5:3], start_b);
		if (dend[5:3] !== end_b) mismatch("dend[5:3]", dend[5:3], end_b);
	endtask

	task automatic phrase_clip();
		load_command(1'b0);
		load_flags(1'b0, flags_word(PIX16, ADDX_PHRASE, 1'b0));
		if (phrase_mode !== 1'b1) mismatch("phrase_mode", phrase_mode, 1);
		// Window edge inside this phrase
		clip_case(16'h0041, 15'h0043, 3'd0, 1'b0);
		// Inner count ends first
		clip_case(16'h0041, 15'h0043, 3'd2, 1'b1);
		finish_test("phrase_clip");
	endtask

	initial begin
		sys_clk = 1'b0;
		reset = 1'b1;
		cmdld = 1'b0;
		a1_flags_ld = 1'b0;
		a2_flags_ld = 1'b0;
		gpu_din = '0;
		a1updatei = 1'b0;
		a1fupdatei = 1'b0;
		a2updatei = 1'b0;
		srca_addi = 1'b0;
		dsta_addi = 1'b0;
		atick = 2'b00;
		a1_x = '0;
		a2_x = '0;
		a1_win_x = '0;
		pixa = 3'd0;
		icount = 3'd0;
		inner0 = 1'b0;
		step_inner = 1'b0;
		dest_cycle_1 = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(62528));
		repeat (4) @(posedge sys_clk);
		#1;
		reset = 1'b0;
		reset_state();
		flags_select();
		adder_steer();
		pixel_extent_mode();
		phrase_clip();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/blit_addr_ctrl_properties.sv */
// Concurrent checks on the pointer and fraction load strobes of the adder steering
`default_nettype none

module blit_addr_ctrl_properties (
	input wire sys_clk,
	input wire reset,
	input wire dsta2,
	input wire a1updatei,
	input wire a1fupdatei,
	input wire a2updatei,
	input wire srca_addi,
	input wire dsta_addi,
	input wire a1ptrldi,
	input wire a1fracldi,
	input wire a2ptrldi
);

	// Strobes clear in the cycle after a reset edge
	assert property (@(posedge sys_clk) reset |=> !(a1ptrldi || a1fracldi || a2ptrldi))
		else $error("Load strobe high in the cycle after reset");

	// A1 pointer load follows an A1 add or update request by one cycle
	assert property (@(posedge sys_clk) disable iff (reset)
		a1ptrldi |-> ($past(a1updatei) || $past(dsta2 ? srca_addi : dsta_addi)))
		else $error("a1ptrldi high without an A1 request in the previous cycle");

	// Same for A2, which takes the other side of the swap
	assert property (@(posedge sys_clk) disable iff (reset)
		a2ptrldi |-> ($past(a2updatei) || $past(dsta2 ? dsta_addi : srca_addi)))
		else $error("a2ptrldi high without an A2 request in the previous cycle");

	// Fraction load only after a fraction update or an A1 add
	assert property (@(posedge sys_clk) disable iff (reset)
		a1fracldi |-> ($past(a1fupdatei) || $past(dsta2 ? srca_addi : dsta_addi)))
		else $error("a1fracldi high without an A1 request in the previous cycle");

endmodule

bind addr_adder_sel blit_addr_ctrl_properties u_props (
	.sys_clk(sys_clk),
	.reset(reset),
	.dsta2(dsta2),
	.a1updatei(a1updatei),
	.a1fupdatei(a1fupdatei),
	.a2updatei(a2updatei),
	.srca_addi(srca_addi),
	.dsta_addi(dsta_addi),
	.a1ptrldi(a1ptrldi),
	.a1fracldi(a1fracldi),
	.a2ptrldi(a2ptrldi)
);

`default_nettype wire

/* source/blit_addr_ctrl.sv */
// Blitter address control top: command registers, adder steering, pixel extent
`include "blit_macros.svh"
`default_nettype none

module blit_addr_ctrl (
	input wire sys_clk,
	input wire reset,
	input wire cmdld,
	input wire a1_flags_ld,
	input wire a2_flags_ld,
	input wire [`BLIT_GPU_W-1:0] gpu_din,
	input wire a1updatei,
	input wire a1fupdatei,
	input wire a2updatei,
	input wire srca_addi,
	input wire dsta_addi,
	input wire [1:0] atick,
	input wire [`BLIT_PTR_X_W-1:0] a1_x,
	input wire [`BLIT_PTR_X_W-1:0] a2_x,
	input wire [`BLIT_WIN_X_W-1:0] a1_win_x,
	input wire [2:0] pixa,
	input wire [2:0] icount,
	input wire inner0,
	input wire step_inner,
	input wire dest_cycle_1,
	output logic dsta2,
	output logic [2:0] addasel,
	output logic [1:0] addbsel,
	output logic addareg,
	output logic addqsel,
	output logic [2:0] adda_xconst,
	output logic adda_yconst,
	output logic [2:0] modx,
	output logic suba_x,
	output logic suba_y,
	output logic a1ptrldi,
	output logic a1fracldi,
	output logic a2ptrldi,
	output blit_pkg::pixsize_t pixsize,
	output logic [`BLIT_PTR_X_W-1:0] dstxp,
	output logic phrase_mode,
	output logic phrase_cycle,
	output blit_pkg::phrase_ofs_t dstart,
	output blit_pkg::phrase_ofs_t dend,
	output logic [3:0] pwidth
);
	import blit_pkg::*;

	// Flags fields shared by the adder steering and the extent logic
	pixsize_t a1_pixsize;
	pixsize_t a2_pixsize;
	addx_t a1addx;
	addx_t a2addx;
	logic a1addy;
	logic a2addy;
	logic a1xsign;
	logic a1ysign;
	logic a2xsign;
	logic a2ysign;

	// Port names match throughout
	blit_cmd_regs u_regs (.*);

	addr_adder_sel u_adder (.*);

	pixel_extent u_extent (.*);

endmodule

`default_nettype wire

/* source/pixel_extent.sv */
// Destination pixel extent in a phrase: start/end offsets, pipeline and width
`include "blit_macros.svh"
`default_nettype none

module pixel_extent (
	input wire sys_clk,
	input wire reset,
	input wire dsta2,
	input wire blit_pkg::pixsize_t a1_pixsize,
	input wire blit_pkg::pixsize_t a2_pixsize,
	input wire blit_pkg::addx_t a1addx,
	input wire blit_pkg::addx_t a2addx,
	input wire [`BLIT_PTR_X_W-1:0] a1_x,
	input wire [`BLIT_PTR_X_W-1:0] a2_x,
	input wire [`BLIT_WIN_X_W-1:0] a1_win_x,
	input wire [2:0] pixa,
	input wire [2:0] icount,
	input wire inner0,
	input wire [1:0] atick,
	input wire step_inner,
	input wire dest_cycle_1,
	output blit_pkg::pixsize_t pixsize,
	output logic [`BLIT_PTR_X_W-1:0] dstxp,
	output logic phrase_mode,
	output logic phrase_cycle,
	output blit_pkg::phrase_ofs_t dstart,
	output blit_pkg::phrase_ofs_t dend,
	output logic [3:0] pwidth
);
	import blit_pkg::*;

	logic pcsela2;
	logic [2:0] start_hi;
	logic [2:0] emask;
	logic [`BLIT_OFS_W-1:0] pix_step;
	phrase_ofs_t dstarta;
	phrase_ofs_t denda;
	phrase_ofs_t dstartb;
	phrase_ofs_t dendb;
	phrase_ofs_t dstartbl;
	phrase_ofs_t dendbl;
	phrase_ofs_t dstartp;
	phrase_ofs_t dendp;

	phrase_end_clip u_clip (
		.dstxp(dstxp),
		.a1_win_x(a1_win_x),
		.pixsize(pixsize),
		.icount(icount),
		.inner0(inner0),
		.emask(emask)
	);

	// Destination pointer
	assign pixsize = dsta2 ? a2_pixsize : a1_pixsize;
	assign dstxp = dsta2 ? a2_x : a1_x;
	assign phrase_mode = dsta2 ? (a2addx == ADDX_PHRASE) : (a1addx == ADDX_PHRASE);

	// Pointer active this cycle, A2 when it matches the destination phase
	assign pcsela2 = ~(dsta2 ^ dest_cycle_1);
	assign phrase_cycle = pcsela2 ? (a2addx == ADDX_PHRASE) : (a1addx == ADDX_PHRASE);

	// Phrase mode works in bytes, pixel mode in bits
	assign start_hi = phrase_ofs_scale(dstxp[2:0], pixsize);
	assign pix_step = `BLIT_OFS_W'(1) << pixsize;
	assign dstarta = phrase_mode ? {start_hi, 3'b000} : {3'b000, pixa};
	assign denda = phrase_mode ? {emask, 3'b000} : pix_step + {3'b000, pixa};

	// Stage b samples on atick[1] and holds otherwise
	assign dstartb = atick[1] ? dstarta : dstartbl;
	assign dendb = atick[1] ? denda : dendbl;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			dstartbl <= '0;
			dendbl <= '0;
			dstartp <= '0;
			dendp <= '0;
			dstart <= '0;
			dend <= '0;
		end else begin
			dstartbl <= dstartb;
			dendbl <= dendb;
			// Stage p advances with the inner loop
			if (step_inner) begin
				dstartp <= dstartb;
				dendp <= dendb;
			end
			dstart <= dstartp;
			dend <= dendp;
		end
	end

	// Width in bytes, bit 3 flags a full phrase
	assign pwidth[2:0] = dendp[5:3] - dstartp[5:3];
	assign pwidth[3] = ~(|dendp[5:3] | |dstartp[5:3]);

endmodule

`default_nettype wire

/* source/phrase_end_clip.sv */
// End-of-phrase clipping against the A1 window edge and the inner-loop count
`include "blit_macros.svh"
`default_nettype none

module phrase_end_clip (
	input wire [`BLIT_PTR_X_W-1:0] dstxp,
	input wire [`BLIT_WIN_X_W-1:0] a1_win_x,
	input wire blit_pkg::pixsize_t pixsize,
	input wire [2:0] icount,
	input wire inner0,
	output logic [2:0] emask
);
	import blit_pkg::*;

	logic [`BLIT_WIN_X_W-1:1] pseq;
	logic wide_pix;
	logic penden;
	logic [2:0] window_end;
	logic [2:0] inner_end;
	logic [3:0] window_rank;
	logic [3:0] inner_rank;

	// Bit-wise mismatch between pointer and window
	assign pseq = dstxp[`BLIT_WIN_X_W-1:1] ^ a1_win_x[`BLIT_WIN_X_W-1:1];
	assign wide_pix = (pixsize == PIX16) || (pixsize == PIX32);

	// Window edge in this phrase
	// Compare only above the pixel index bits for this depth
	assign penden = ~|pseq[`BLIT_WIN_X_W-1:3]
		& ~(pseq[2] & wide_pix)
		& ~(pseq[1] & (pixsize == PIX32));

	// Candidate ends as byte offsets
	assign window_end = penden ? phrase_ofs_scale(a1_win_x[2:0], pixsize) : 3'b000;
	assign inner_end = inner0 ? phrase_ofs_scale(icount, pixsize) : 3'b000;

	// Zero stands for the full phrase, so rank it as 8
	assign window_rank = {window_end == 3'b000, window_end};
	assign inner_rank = {inner_end == 3'b000, inner_end};

	// Nearer end wins
	assign emask = (window_rank > inner_rank) ? inner_end : window_end;

endmodule

`default_nettype wire

/* source/addr_adder_sel.sv */
// Pointer adder steering: operand selects, subtract flags and A1/A2 load strobes
`default_nettype none

module addr_adder_sel (
	input wire sys_clk,
	input wire reset,
	input wire dsta2,
	input wire blit_pkg::pixsize_t a1_pixsize,
	input wire blit_pkg::pixsize_t a2_pixsize,
	input wire blit_pkg::addx_t a1addx,
	input wire blit_pkg::addx_t a2addx,
	input wire a1addy,
	input wire a2addy,
	input wire a1xsign,
	input wire a1ysign,
	input wire a2xsign,
	input wire a2ysign,
	input wire a1updatei,
	input wire a1fupdatei,
	input wire a2updatei,
	input wire srca_addi,
	input wire dsta_addi,
	input wire [1:0] atick,
	output logic [2:0] addasel,
	output logic [1:0] addbsel,
	output logic addareg,
	output logic addqsel,
	output logic [2:0] adda_xconst,
	output logic adda_yconst,
	output logic [2:0] modx,
	output logic suba_x,
	output logic suba_y,
	output logic a1ptrldi,
	output logic a1fracldi,
	output logic a2ptrldi
);
	import blit_pkg::*;

	logic a1_addi;
	logic a2_addi;
	logic a1_fracadd;
	logic a2_fracadd;
	logic [2:0] addaseli;
	logic [1:0] addbseli;
	logic addaregi;
	logic a1update;
	logic a1fupdate;
	logic a2update;
	logic a1_add;
	logic a2_add;
	logic [2:0] a1xp;
	logic [2:0] a2xp;
	logic [2:0] a1_xconst;
	logic [2:0] a2_xconst;
	logic [2:0] mask_a1;
	logic [2:0] mask_a2;

	// log2 of pixels per phrase
	function automatic logic [2:0] phrase_step(pixsize_t ps);
		case (ps)
			PIX1: phrase_step = 3'd6;
			PIX2: phrase_step = 3'd5;
			PIX4: phrase_step = 3'd4;
			PIX8: phrase_step = 3'd3;
			PIX16: phrase_step = 3'd2;
			PIX32: phrase_step = 3'd1;
			default: phrase_step = 3'd0;
		endcase
	endfunction

	// Adder X constant code per add mode
	function automatic logic [2:0] x_const(addx_t mode, logic [2:0] xp);
		case (mode)
			ADDX_PHRASE: x_const = xp;
			ADDX_PIXEL: x_const = 3'b000;
			default: x_const = 3'b111;
		endcase
	endfunction

	// Source/destination requests onto A1 and A2
	assign a1_addi = dsta2 ? srca_addi : dsta_addi;
	assign a2_addi = dsta2 ? dsta_addi : srca_addi;
	assign a1_fracadd = a1_addi && (a1addx == ADDX_FRAC);
	assign a2_fracadd = a2_addi && (a2addx == ADDX_FRAC);

	// Operand selects, fraction steps go through the fraction register
	assign addaseli[2] = a2updatei;
	assign addaseli[1] = a1_fracadd;
	assign addaseli[0] = a1fupdatei | (a1_fracadd & atick[0]);
	assign addbseli[0] = a2updatei | a2_addi;
	assign addbseli[1] = addaseli[0];
	assign addaregi = a1_fracadd | a2_fracadd | a1updatei | a1fupdatei | a2updatei;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			a1update <= 1'b0;
			a1fupdate <= 1'b0;
			a2update <= 1'b0;
			a1_add <= 1'b0;
			a2_add <= 1'b0;
			addasel <= 3'b000;
			addbsel <= 2'b00;
			addareg <= 1'b0;
		end else begin
			a1update <= a1updatei;
			a1fupdate <= a1fupdatei;
			a2update <= a2updatei;
			a1_add <= a1_addi;
			a2_add <= a2_addi;
			addasel <= addaseli;
			addbsel <= addbseli;
			addareg <= addaregi;
		end
	end

	// X constant follows the pointer being added to
	assign a1xp = phrase_step(a1_pixsize);
	assign a2xp = phrase_step(a2_pixsize);
	assign a1_xconst = x_const(a1addx, a1xp);
	assign a2_xconst = x_const(a2addx, a2xp);
	assign adda_xconst = a2_add ? a2_xconst : a1_xconst;
	assign adda_yconst = a1addy;

	// Phrase modulo mask, phrase adds only
	assign mask_a1 = (a1_add && a1addx == ADDX_PHRASE) ? a1xp : 3'b000;
	assign mask_a2 = (a2_add && a2addx == ADDX_PHRASE) ? a2xp : 3'b000;
	assign modx = a2_add ? mask_a2 : mask_a1;

	assign addqsel = a1_add | a2_add | a1update | a1fupdate | a2update;

	// Negative steps subtract; X only in pixel mode
	assign suba_x = (a1_add & (a1addx == ADDX_PIXEL) & a1xsign)
		| (a2_add & (a2addx == ADDX_PIXEL) & a2xsign);
	assign suba_y = (a1_add & a1addy & a1ysign) | (a2_add & a2addy & a2ysign);

	// Pointer loads on atick[1], fraction load on atick[0]
	assign a1ptrldi = a1update | (atick[1] & a1_add);
	assign a1fracldi = a1fupdate | (atick[0] & a1_add & (a1addx == ADDX_FRAC));
	assign a2ptrldi = a2update | (atick[1] & a2_add);

endmodule

`default_nettype wire

/* source/blit_cmd_regs.sv */
// Blitter command and A1/A2 pointer-flags registers, loaded from the GPU bus
`include "blit_macros.svh"
`default_nettype none

module blit_cmd_regs (
	input wire sys_clk,
	input wire reset,
	input wire cmdld,
	input wire a1_flags_ld,
	input wire a2_flags_ld,
	input wire [`BLIT_GPU_W-1:0] gpu_din,
	output logic dsta2,
	output blit_pkg::pixsize_t a1_pixsize,
	output blit_pkg::pixsize_t a2_pixsize,
	output blit_pkg::addx_t a1addx,
	output blit_pkg::addx_t a2addx,
	output logic a1addy,
	output logic a2addy,
	output logic a1xsign,
	output logic a1ysign,
	output logic a2xsign,
	output logic a2ysign
);
	import blit_pkg::*;

	// Destination select, only from a command write
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			dsta2 <= 1'b0;
		end else if (cmdld) begin
			dsta2 <= gpu_din[`BLIT_CMD_DSTA2_BIT];
		end
	end

	// A1 flags word
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			a1_pixsize <= PIX1;
			a1addx <= ADDX_PHRASE;
			a1addy <= 1'b0;
			a1xsign <= 1'b0;
			a1ysign <= 1'b0;
		end else if (a1_flags_ld) begin
			a1_pixsize <= pixsize_t'(gpu_din[`BLIT_FLG_PIXSIZE_LSB +: 3]);
			a1addx <= addx_t'(gpu_din[`BLIT_FLG_ADDX_LSB +: 2]);
			a1addy <= gpu_din[`BLIT_FLG_ADDY_BIT];
			a1xsign <= gpu_din[`BLIT_FLG_XSIGN_BIT];
			a1ysign <= gpu_din[`BLIT_FLG_YSIGN_BIT];
		end
	end

	// A2 flags word, same layout as A1
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			a2_pixsize <= PIX1;
			a2addx <= ADDX_PHRASE;
			a2addy <= 1'b0;
			a2xsign <= 1'b0;
			a2ysign <= 1'b0;
		end else if (a2_flags_ld) begin
			a2_pixsize <= pixsize_t'(gpu_din[`BLIT_FLG_PIXSIZE_LSB +: 3]);
			a2addx <= addx_t'(gpu_din[`BLIT_FLG_ADDX_LSB +: 2]);
			a2addy <= gpu_din[`BLIT_FLG_ADDY_BIT];
			a2xsign <= gpu_din[`BLIT_FLG_XSIGN_BIT];
			a2ysign <= gpu_din[`BLIT_FLG_YSIGN_BIT];
		end
	end

endmodule

`default_nettype wire

/* source/blit_pkg.sv */
// Blitter address control types: pixel depth, X add mode and phrase offsets
`default_nettype none

package blit_pkg;

	// Pixel depth, log2 of bits per pixel
	typedef enum logic [2:0] {
		PIX1 = 3'd0,
		PIX2 = 3'd1,
		PIX4 = 3'd2,
		PIX8 = 3'd3,
		PIX16 = 3'd4,
		PIX32 = 3'd5
	} pixsize_t;

	// X step applied on each pointer update
	typedef enum logic [1:0] {
		ADDX_PHRASE = 2'd0,
		ADDX_PIXEL = 2'd1,
		ADDX_ZERO = 2'd2,
		ADDX_FRAC = 2'd3
	} addx_t;

	// Bit offset in a 64-bit phrase
	typedef logic [5:0] phrase_ofs_t;

	// Pixel index within a phrase to byte offset (bits 5:3)
	// Only 8, 16 and 32 bpp have byte-aligned pixels
	function automatic logic [2:0] phrase_ofs_scale(logic [2:0] idx, pixsize_t ps);
		case (ps)
			PIX8: phrase_ofs_scale = idx;
			PIX16: phrase_ofs_scale = {idx[1:0], 1'b0};
			PIX32: phrase_ofs_scale = {idx[0], 2'b00};
			default: phrase_ofs_scale = 3'b000;
		endcase
	endfunction

endpackage

`default_nettype wire

/* source/blit_macros.svh */
// Blitter address control: bus widths and command/flags field positions
`ifndef BLIT_MACROS_SVH
`define BLIT_MACROS_SVH
`default_nettype none

// GPU data bus
`define BLIT_GPU_W 32

// Pointer and window X widths
`define BLIT_PTR_X_W 16
`define BLIT_WIN_X_W 15

// Bit offset inside a 64-bit phrase
`define BLIT_OFS_W 6

// Command word, A2 is the destination when set
`define BLIT_CMD_DSTA2_BIT 11

// Flags word fields
`define BLIT_FLG_PIXSIZE_LSB 3
`define BLIT_FLG_ADDX_LSB 16
`define BLIT_FLG_ADDY_BIT 18
`define BLIT_FLG_XSIGN_BIT 19
`define BLIT_FLG_YSIGN_BIT 20

`default_nettype wire
`endif
